// ==== Makefile ====
# Verilator build and run of the decode/execute slice testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run, look for the pass message in $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f sources.f --top-module datapath_tb -o datapath_sim
	./obj_dir/datapath_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sources.f ====
src/cpu_types_pkg.sv
src/alu_pkg.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/execute_unit.sv
src/datapath_top.sv
test/datapath_chk.sv
test/datapath_tb.sv

// ==== src/alu.sv ====
// ---------------------------------------------------------------------
// combinational alu, ten operations plus zero, negative and
// signed overflow flags
// shifts move port_b by shamt, port_a is ignored for them
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module alu
   import cpu_types_pkg::*, alu_pkg::*;
(
   input  word_t      port_a,
   input  word_t      port_b,
   input  aluop_t     alu_op,
   input  logic [4:0] shamt,
   output word_t      out_val,
   output alu_flags_t flags
);

   word_t sum;
   word_t diff;
   logic  ovf_add;
   logic  ovf_sub;
   logic  ovf;

   assign sum  = port_a + port_b;
   assign diff = port_a - port_b;

   // same signs in, different sign out
   assign ovf_add = (port_a[31] == port_b[31]) && (sum[31] != port_a[31]);
   // opposite signs in, result sign flips from a
   assign ovf_sub = (port_a[31] != port_b[31]) && (diff[31] != port_a[31]);

   always_comb begin
      ovf = 1'b0;
      case (alu_op)
         ALU_ADD: begin
            out_val = sum;
            ovf     = ovf_add;
         end
         ALU_SUB: begin
            out_val = diff;
            ovf     = ovf_sub;
         end
         ALU_AND:  out_val = port_a & port_b;
         ALU_OR:   out_val = port_a | port_b;
         ALU_XOR:  out_val = port_a ^ port_b;
         ALU_NOR:  out_val = ~(port_a | port_b);
         ALU_SLL:  out_val = port_b << shamt;
         ALU_SRL:  out_val = port_b >> shamt;   // logical, zero fill
         ALU_SLT:  out_val = {31'b0, $signed(port_a) < $signed(port_b)};
         ALU_SLTU: out_val = {31'b0, port_a < port_b};
         default:  out_val = '0;
      endcase
   end

   assign flags[FLAG_ZERO] = (out_val == '0);
   assign flags[FLAG_NEG]  = out_val[31];
   assign flags[FLAG_OVF]  = ovf;

endmodule

`default_nettype wire

// ==== src/alu_pkg.sv ====
// ---------------------------------------------------------------------
// datapath operation types shared by decode and execute
// alu operation codes, flag bit positions, port b source select
// ---------------------------------------------------------------------
`default_nettype none

package alu_pkg;

   typedef enum logic [3:0] {
      ALU_SLL  = 4'b0000,
      ALU_SRL  = 4'b0001,
      ALU_ADD  = 4'b0010,
      ALU_SUB  = 4'b0011,
      ALU_AND  = 4'b0100,
      ALU_OR   = 4'b0101,
      ALU_XOR  = 4'b0110,
      ALU_NOR  = 4'b0111,
      ALU_SLT  = 4'b1010,   // signed compare
      ALU_SLTU = 4'b1011    // unsigned compare
   } aluop_t;

   typedef logic [2:0] alu_flags_t;

   localparam int FLAG_ZERO = 0;  // result all zero
   localparam int FLAG_NEG  = 1;  // result msb
   localparam int FLAG_OVF  = 2;  // signed overflow, add/sub only

   // port b source
   typedef enum logic [1:0] {
      SRC_RT  = 2'd0,  // register rt
      SRC_IMM = 2'd1,  // extended imm16
      SRC_LUI = 2'd2   // imm16 in upper half
   } alusrc_t;

endpackage

`default_nettype wire

// ==== src/control_unit.sv ====
// ---------------------------------------------------------------------
// combinational decode, splits instr into register fields and
// immediate, then derives control levels and alu operation
// purely combinational, no clock
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module control_unit
   import cpu_types_pkg::*, alu_pkg::*;
(
   input  word_t    instr,
   output regbits_t rs,
   output regbits_t rt,
   output regbits_t rd,
   output logic [4:0]  shamt,
   output logic [15:0] imm16,
   output logic     regdst,   // 1 = write rd, 0 = write rt
   output logic     extop,    // 1 = sign extend, 0 = zero extend
   output logic     regwr,
   output logic     memwr,
   output logic     memtoreg,
   output logic     is_beq,
   output logic     is_bne,
   output alusrc_t  alu_src,
   output aluop_t   alu_op
);

   opcode_t op;
   funct_t  funct;
   logic    funct_ok;   // funct is one of the supported R-type ops
   aluop_t  alu_op_rtype;

   // field split
   assign op    = opcode_t'(instr[31:26]);
   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign rd    = instr[15:11];
   assign shamt = instr[10:6];
   assign funct = funct_t'(instr[5:0]);
   assign imm16 = instr[15:0];

   // R-type funct to alu op
   always_comb begin
      funct_ok = 1'b1;
      case (funct)
         ADD, ADDU: alu_op_rtype = ALU_ADD;   // no trap on overflow
         SUB, SUBU: alu_op_rtype = ALU_SUB;
         AND:       alu_op_rtype = ALU_AND;
         OR:        alu_op_rtype = ALU_OR;
         XOR:       alu_op_rtype = ALU_XOR;
         NOR:       alu_op_rtype = ALU_NOR;
         SLL:       alu_op_rtype = ALU_SLL;
         SRL:       alu_op_rtype = ALU_SRL;
         SLT:       alu_op_rtype = ALU_SLT;
         SLTU:      alu_op_rtype = ALU_SLTU;
         default: begin
            alu_op_rtype = ALU_ADD;
            funct_ok     = 1'b0;               // unknown funct, no write
         end
      endcase
   end

   // opcode to control levels
   always_comb begin
      regdst   = 1'b0;
      extop    = 1'b1;       // sign extend unless logical imm
      regwr    = 1'b0;
      memwr    = 1'b0;
      memtoreg = 1'b0;
      is_beq   = 1'b0;
      is_bne   = 1'b0;
      alu_src  = SRC_RT;
      alu_op   = ALU_ADD;
      case (op)
         RTYPE: begin
            regdst = 1'b1;
            regwr  = funct_ok;
            alu_op = alu_op_rtype;
         end
         ORI, ANDI, XORI: begin
            extop   = 1'b0;
            regwr   = 1'b1;
            alu_src = SRC_IMM;
            alu_op  = (op == ORI)  ? ALU_OR  :
                      (op == ANDI) ? ALU_AND : ALU_XOR;
         end
         LUI: begin
            extop   = 1'b0;
            regwr   = 1'b1;
            alu_src = SRC_LUI;
            alu_op  = ALU_OR;   // 0 | {imm16, 16'b0}
         end
         LW: begin
            regwr    = 1'b1;
            memtoreg = 1'b1;
            alu_src  = SRC_IMM;   // base + offset
         end
         SW: begin
            memwr   = 1'b1;
            alu_src = SRC_IMM;
         end
         BEQ: begin
            is_beq = 1'b1;
            alu_op = ALU_SUB;     // rs - rt, zero means equal
         end
         BNE: begin
            is_bne = 1'b1;
            alu_op = ALU_SUB;
         end
         default: ;               // unsupported op, all levels low
      endcase
   end

endmodule

`default_nettype wire

// ==== src/cpu_types_pkg.sv ====
// ---------------------------------------------------------------------
// instruction set encoding for the decode/execute slice
// word and register index types, opcode and funct values
// import into any module that splits or carries instruction fields
// ---------------------------------------------------------------------
`default_nettype none

package cpu_types_pkg;

   typedef logic [31:0] word_t;    // data and instruction word
   typedef logic [4:0]  regbits_t; // register index, 32 registers

   // primary opcode field, instr[31:26]
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,            // decode continues on funct
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      LW    = 6'b100011,
      SW    = 6'b101011
   } opcode_t;

   // funct field for R-type, instr[5:0]
   typedef enum logic [5:0] {
      SLL   = 6'b000000,
      SRL   = 6'b000010,
      ADD   = 6'b100000,
      ADDU  = 6'b100001,
      SUB   = 6'b100010,
      SUBU  = 6'b100011,
      AND   = 6'b100100,
      OR    = 6'b100101,
      XOR   = 6'b100110,
      NOR   = 6'b100111,
      SLT   = 6'b101010,
      SLTU  = 6'b101011
   } funct_t;

endpackage

`default_nettype wire

// ==== src/datapath_top.sv ====
// ---------------------------------------------------------------------
// top of the decode/execute slice, one instruction per instr_valid
// results registered one cycle later with a result_valid pulse
// load data enters alongside the instruction it belongs to
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module datapath_top
   import cpu_types_pkg::*, alu_pkg::*;
(
   input  logic  CLK,
   input  logic  reset,
   input  logic  instr_valid,
   input  word_t instr,
   input  word_t load_data,
   output word_t result,
   output word_t dcu_addr,
   output word_t dcu_store,
   output logic  result_valid,
   output logic  branch_taken,
   output logic  dcu_ren,
   output logic  dcu_wen
);

   // decode outputs
   regbits_t    rs;
   regbits_t    rt;
   regbits_t    rd;
   logic [4:0]  shamt;
   logic [15:0] imm16;
   logic        regdst;
   logic        extop;
   logic        regwr;
   logic        memwr;
   logic        memtoreg;
   logic        is_beq;
   logic        is_bne;
   alusrc_t     alu_src;
   aluop_t      alu_op;

   // register file ports
   word_t       rdat1;
   word_t       rdat2;
   logic        wen;
   regbits_t    wsel;
   word_t       wdat;

   control_unit control_unit_inst (
      .instr    (instr),
      .rs       (rs),
      .rt       (rt),
      .rd       (rd),
      .shamt    (shamt),
      .imm16    (imm16),
      .regdst   (regdst),
      .extop    (extop),
      .regwr    (regwr),
      .memwr    (memwr),
      .memtoreg (memtoreg),
      .is_beq   (is_beq),
      .is_bne   (is_bne),
      .alu_src  (alu_src),
      .alu_op   (alu_op)
   );

   register_file register_file_inst (
      .CLK   (CLK),
      .reset (reset),
      .wen   (wen),
      .wsel  (wsel),
      .rsel1 (rs),
      .rsel2 (rt),
      .wdat  (wdat),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

   execute_unit execute_unit_inst (
      .CLK          (CLK),
      .reset        (reset),
      .instr_valid  (instr_valid),
      .rt           (rt),
      .rd           (rd),
      .shamt        (shamt),
      .imm16        (imm16),
      .regdst       (regdst),
      .extop        (extop),
      .regwr        (regwr),
      .memwr        (memwr),
      .memtoreg     (memtoreg),
      .is_beq       (is_beq),
      .is_bne       (is_bne),
      .alu_src      (alu_src),
      .alu_op       (alu_op),
      .rdat1        (rdat1),
      .rdat2        (rdat2),
      .load_data    (load_data),
      .wen          (wen),
      .wsel         (wsel),
      .wdat         (wdat),
      .result       (result),
      .dcu_addr     (dcu_addr),
      .dcu_store    (dcu_store),
      .result_valid (result_valid),
      .branch_taken (branch_taken),
      .dcu_ren      (dcu_ren),
      .dcu_wen      (dcu_wen)
   );

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
// ---------------------------------------------------------------------
// execute stage, extends the immediate, picks alu operands, decides
// branches and builds the write-back, then registers the results
// one cycle after instr_valid; register write goes out same cycle
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module execute_unit
   import cpu_types_pkg::*, alu_pkg::*;
(
   input  logic        CLK,
   input  logic        reset,
   input  logic        instr_valid,
   input  regbits_t    rt,
   input  regbits_t    rd,
   input  logic [4:0]  shamt,
   input  logic [15:0] imm16,
   input  logic        regdst,
   input  logic        extop,
   input  logic        regwr,
   input  logic        memwr,
   input  logic        memtoreg,
   input  logic        is_beq,
   input  logic        is_bne,
   input  alusrc_t     alu_src,
   input  aluop_t      alu_op,
   input  word_t       rdat1,
   input  word_t       rdat2,
   input  word_t       load_data,
   output logic        wen,
   output regbits_t    wsel,
   output word_t       wdat,
   output word_t       result,
   output word_t       dcu_addr,
   output word_t       dcu_store,
   output logic        result_valid,
   output logic        branch_taken,
   output logic        dcu_ren,
   output logic        dcu_wen
);

   word_t      imm_ext;
   word_t      port_a;
   word_t      port_b;
   word_t      alu_out;
   alu_flags_t alu_flags;
   logic       take;

   assign imm_ext = extop ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

   // lui ignores rs so the upper value passes through the or
   assign port_a = (alu_src == SRC_LUI) ? '0 : rdat1;

   always_comb begin
      case (alu_src)
         SRC_IMM: port_b = imm_ext;
         SRC_LUI: port_b = {imm16, 16'b0};
         default: port_b = rdat2;
      endcase
   end

   alu alu_inst (
      .port_a  (port_a),
      .port_b  (port_b),
      .alu_op  (alu_op),
      .shamt   (shamt),
      .out_val (alu_out),
      .flags   (alu_flags)
   );

   assign take = (is_beq &  alu_flags[FLAG_ZERO]) |
                 (is_bne & ~alu_flags[FLAG_ZERO]);

   // write-back to register file
   assign wen  = instr_valid & regwr;
   assign wsel = regdst ? rd : rt;
   assign wdat = memtoreg ? load_data : alu_out;   // load lands same cycle

   always_ff @(posedge CLK) begin
      if (reset) begin
         result_valid <= 1'b0;
         branch_taken <= 1'b0;
         dcu_ren      <= 1'b0;
         dcu_wen      <= 1'b0;
         result       <= '0;
         dcu_addr     <= '0;
         dcu_store    <= '0;
      end else begin
         result_valid <= instr_valid;            // one-cycle pulse per instr
         dcu_ren      <= instr_valid & memtoreg;
         dcu_wen      <= instr_valid & memwr;
         if (instr_valid) begin                  // data holds when idle
            branch_taken <= take;
            result       <= wdat;
            dcu_addr     <= alu_out;             // rs + sext(imm) for lw/sw
            dcu_store    <= rdat2;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
// ---------------------------------------------------------------------
// 32 x 32-bit register file, register 0 reads as zero
// two combinational read ports, one write port at the clock edge
// a write is visible to reads from the following cycle on
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module register_file
   import cpu_types_pkg::*;
(
   input  logic     CLK,
   input  logic     reset,
   input  logic     wen,
   input  regbits_t wsel,
   input  regbits_t rsel1,
   input  regbits_t rsel2,
   input  word_t    wdat,
   output word_t    rdat1,
   output word_t    rdat2
);

   word_t regs [32];

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;            // whole file clears
         end
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;          // writes to r0 dropped
      end
   end

   // no bypass, write lands at the edge
   assign rdat1 = regs[rsel1];
   assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

// ==== test/datapath_chk.sv ====
// ---------------------------------------------------------------------
// protocol assertions for the decode/execute slice
// bound into datapath_top, watches strobes and regfile reads
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module datapath_chk (
   input logic        CLK,
   input logic        reset,
   input logic        instr_valid,
   input logic        result_valid,
   input logic        dcu_ren,
   input logic        dcu_wen,
   input logic [4:0]  rs,          // regfile read addresses
   input logic [4:0]  rt,
   input logic [31:0] rdat1,       // regfile read data
   input logic [31:0] rdat2
);

   // reset edge leaves no result pulse behind
   assert property (@(posedge CLK) reset |=> !result_valid)
      else $error("result_valid high in the cycle after reset");

   // load and store strobes are exclusive
   assert property (@(posedge CLK) !(dcu_ren && dcu_wen))
      else $error("dcu_ren and dcu_wen high together");

   assert property (@(posedge CLK) (!reset && instr_valid) |=> result_valid)
      else $error("result_valid missing one cycle after instr_valid");

   assert property (@(posedge CLK) !instr_valid |=> !result_valid)
      else $error("result_valid high without a preceding instr_valid");

   // no write on an idle edge so a steady read address keeps its data
   assert property (@(posedge CLK) (!reset && !instr_valid) |=>
                    (!$stable(rs) || $stable(rdat1)))
      else $error("register on read port 1 changed without instr_valid");

   assert property (@(posedge CLK) (!reset && !instr_valid) |=>
                    (!$stable(rt) || $stable(rdat2)))
      else $error("register on read port 2 changed without instr_valid");

endmodule

bind datapath_top datapath_chk datapath_chk_inst (
   .CLK          (CLK),
   .reset        (reset),
   .instr_valid  (instr_valid),
   .result_valid (result_valid),
   .dcu_ren      (dcu_ren),
   .dcu_wen      (dcu_wen),
   .rs           (rs),
   .rt           (rt),
   .rdat1        (rdat1),
   .rdat2        (rdat2)
);

`default_nettype wire

// ==== test/datapath_stimulus.txt ====
// valid instr load_data exp_result flags(bit2 branch_taken, bit1 dcu_ren, bit0 dcu_wen)
// chk_addr exp_dcu_addr exp_dcu_store, addr/store compared only when chk_addr is 1
1 34011234 00000000 00001234 0 0 00000000 00000000
1 3C028000 00000000 80000000 0 0 00000000 00000000
1 3442FFFF 00000000 8000FFFF 0 0 00000000 00000000
1 30430F0F 00000000 00000F0F 0 0 00000000 00000000
1 3824FFFF 00000000 0000EDCB 0 0 00000000 00000000
1 00242820 00000000 0000FFFF 0 0 00000000 00000000
1 00223022 00000000 7FFF1235 0 0 00000000 00000000
1 00603827 00000000 FFFFF0F0 0 0 00000000 00000000
1 00024100 00000000 000FFFF0 0 0 00000000 00000000
1 00024A02 00000000 008000FF 0 0 00000000 00000000
1 0041502A 00000000 00000001 0 0 00000000 00000000
1 0041582B 00000000 00000000 0 0 00000000 00000000
1 00210020 00000000 00002468 0 0 00000000 00000000
1 00056020 00000000 0000FFFF 0 0 00000000 00000000
1 8C2D0010 CAFEF00D CAFEF00D 2 1 00001244 00000000
0 3401BEEF 00000000 CAFEF00D 0 1 00001244 00000000
1 01A07021 00000000 CAFEF00D 0 0 00000000 00000000
1 AC2DFFFC 00000000 00001230 1 1 00001230 CAFEF00D
1 10210008 00000000 00000000 4 1 00000000 00001234
1 14220008 00000000 7FFF1235 4 0 00000000 00000000
1 10240008 00000000 FFFF2469 0 0 00000000 00000000
1 00207825 00000000 00001234 0 0 00000000 00000000
0 00000000 00000000 00001234 0 0 00000000 00000000

// ==== test/datapath_tb.sv ====
// ---------------------------------------------------------------------
// testbench for the decode/execute slice, vectors come from the
// stimulus file, one instruction per cycle, outputs checked one
// cycle later; run from the project root
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module datapath_tb
   import cpu_types_pkg::*;
();

   localparam int FIELDS  = 8;     // words per vector line
   localparam int MAX_VEC = 64;

   logic  CLK;
   logic  reset;
   logic  instr_valid;
   word_t instr;
   word_t load_data;
   word_t result;
   word_t dcu_addr;
   word_t dcu_store;
   logic  result_valid;
   logic  branch_taken;
   logic  dcu_ren;
   logic  dcu_wen;

   word_t vec_mem [FIELDS*MAX_VEC];
   int    n_vec;
   int    checks = 0;
   int    errors = 0;
   int    cycles = 0;
   int    cycle_limit = 1000;   // replaced once the vectors are counted

   datapath_top datapath_top_inst (
      .CLK          (CLK),
      .reset        (reset),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .load_data    (load_data),
      .result       (result),
      .dcu_addr     (dcu_addr),
      .dcu_store    (dcu_store),
      .result_valid (result_valid),
      .branch_taken (branch_taken),
      .dcu_ren      (dcu_ren),
      .dcu_wen      (dcu_wen)
   );

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;   // 40 ns period
   end

   // run length guard
   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout, run still busy after %0d cycles", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic compare_word(input string name, input word_t exp, input word_t got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, got);
      end
   endtask

   task automatic apply_vector(input int v);
      instr_valid = vec_mem[v*FIELDS][0];
      instr       = vec_mem[v*FIELDS+1];
      load_data   = vec_mem[v*FIELDS+2];
   endtask

   task automatic check_vector(input int v);
      int b;
      b = v * FIELDS;
      compare_word("result_valid", {31'b0, vec_mem[b][0]}, {31'b0, result_valid});
      compare_word("result", vec_mem[b+3], result);
      compare_word("branch_taken", {31'b0, vec_mem[b+4][2]}, {31'b0, branch_taken});
      compare_word("dcu_ren", {31'b0, vec_mem[b+4][1]}, {31'b0, dcu_ren});
      compare_word("dcu_wen", {31'b0, vec_mem[b+4][0]}, {31'b0, dcu_wen});
      if (vec_mem[b+5][0]) begin   // memory ops and held values only
         compare_word("dcu_addr", vec_mem[b+6], dcu_addr);
         compare_word("dcu_store", vec_mem[b+7], dcu_store);
      end
   endtask

   task automatic check_reset_state();
      compare_word("result_valid", 32'h0, {31'b0, result_valid});
      compare_word("result", 32'h0, result);
      compare_word("branch_taken", 32'h0, {31'b0, branch_taken});
      compare_word("dcu_ren", 32'h0, {31'b0, dcu_ren});
      compare_word("dcu_wen", 32'h0, {31'b0, dcu_wen});
      compare_word("dcu_addr", 32'h0, dcu_addr);
      compare_word("dcu_store", 32'h0, dcu_store);
   endtask

   initial begin
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      load_data   = '0;

      // unused slots get a valid field above 1, marks the end of the list
      for (int i = 0; i < FIELDS*MAX_VEC; i++) begin
         vec_mem[i] = 32'hFFFF_0000 | i;
      end
      $readmemh("test/datapath_stimulus.txt", vec_mem);
      n_vec = 0;
      while (n_vec < MAX_VEC && vec_mem[n_vec*FIELDS] <= 1) begin
         n_vec++;
      end
      cycle_limit = n_vec + 20;

      repeat (2) @(posedge CLK);
      #2 reset = 1'b0;
      check_reset_state();   // two reset edges seen

      if (n_vec == 0) begin
         errors++;
         $display("no vectors read from the stimulus file");
      end else begin
         apply_vector(0);
      end

      // outputs of vector v are checked while vector v+1 goes in
      for (int v = 0; v < n_vec; v++) begin
         @(posedge CLK);
         #2;
         check_vector(v);
         if (v + 1 < n_vec) begin
            apply_vector(v + 1);
         end else begin
            instr_valid = 1'b0;
            instr       = '0;
         end
      end

      @(posedge CLK);
      #2;
      compare_word("result_valid", 32'h0, {31'b0, result_valid});   // idle tail

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
